// ==== decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    ////////////////////////////////////////
    // Widths

    localparam int INSTR_WIDTH    = 32;
    localparam int PC_WIDTH       = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int REG_DATA_WIDTH = 32;
    localparam int ROB_ID_WIDTH   = 6;
    localparam int OPCODE_WIDTH   = 7;
    localparam int OFFSET_WIDTH   = 32;

    // Architectural registers
    localparam int NUM_REGS = 32;

    ////////////////////////////////////////
    // Instruction field positions

    // Opcode in 31..25
    localparam int OPCODE_LSB = 25;
    // Destination in 24..20
    localparam int RD_LSB     = 20;
    // First source in 19..15
    localparam int RA_LSB     = 15;
    // Second source in 14..10
    localparam int RB_LSB     = 10;
    // Immediate in 14..0, overlaps rb
    localparam int IMM_WIDTH  = 15;

    ////////////////////////////////////////
    // Types

    typedef logic [INSTR_WIDTH-1:0]    instr_t;
    typedef logic [PC_WIDTH-1:0]       pc_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;

    // Ticket space of 64 entries, wraps
    typedef logic [ROB_ID_WIDTH-1:0]   rob_id_t;

    // Immediate after zero extension
    typedef logic [OFFSET_WIDTH-1:0]   offset_t;

    // Any encoding outside this list is illegal
    typedef enum logic [OPCODE_WIDTH-1:0]
    {
        OP_NOP   = 7'd0,
        OP_ADD   = 7'd1,
        OP_SUB   = 7'd2,
        OP_AND   = 7'd3,
        OP_OR    = 7'd4,
        OP_ADDI  = 7'd5,
        OP_MUL   = 7'd6,
        OP_LOAD  = 7'd7,
        OP_STORE = 7'd8
    } opcode_t;

endpackage

`default_nettype wire

// ==== decoded_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decoded_if;

    decode_pkg::opcode_t   opcode;
    decode_pkg::reg_addr_t rd_addr;
    decode_pkg::reg_addr_t ra_addr;
    // rb, or rd for a store
    decode_pkg::reg_addr_t src2_addr;
    logic                  uses_src1;
    logic                  uses_src2;
    logic                  writes_rd;
    logic                  is_mul;
    logic                  illegal;
    decode_pkg::offset_t   offset;

    modport source (output opcode, rd_addr, ra_addr, src2_addr, uses_src1,
                    uses_src2, writes_rd, is_mul, illegal, offset);

    // Dependency tracking
    modport sb_sink (input rd_addr, ra_addr, src2_addr, uses_src1, uses_src2, writes_rd);

    // Operand read addresses
    modport rf_sink (input ra_addr, src2_addr);

    // Payload fields and unit steering
    modport dispatch_sink (input opcode, rd_addr, is_mul, illegal, offset);

endinterface

`default_nettype wire

// ==== writeback_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface writeback_if;

    logic                  wb_valid;
    decode_pkg::reg_addr_t wb_addr;
    decode_pkg::reg_data_t wb_data;
    // Ticket of the instruction that produced wb_data
    decode_pkg::rob_id_t   wb_rob_id;

    modport receiver (input wb_valid, wb_addr, wb_data, wb_rob_id);

endinterface

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
(
    input  decode_pkg::instr_t instr,
    decoded_if.source          dec
);

    decode_pkg::opcode_t opcode;
    logic                is_alu_rr;
    logic                is_addi;
    logic                is_mul_op;
    logic                is_load;
    logic                is_store;
    logic                is_known;

    ////////////////////////////////////////
    // Field slicing

    assign opcode = decode_pkg::opcode_t'(
        instr[decode_pkg::OPCODE_LSB +: decode_pkg::OPCODE_WIDTH]);

    assign dec.opcode  = opcode;
    assign dec.rd_addr = instr[decode_pkg::RD_LSB +: decode_pkg::REG_ADDR_WIDTH];
    assign dec.ra_addr = instr[decode_pkg::RA_LSB +: decode_pkg::REG_ADDR_WIDTH];

    // Stores read the data to write from rd
    assign dec.src2_addr = is_store ? instr[decode_pkg::RD_LSB +: decode_pkg::REG_ADDR_WIDTH]
                                    : instr[decode_pkg::RB_LSB +: decode_pkg::REG_ADDR_WIDTH];

    assign dec.offset = {{(decode_pkg::OFFSET_WIDTH - decode_pkg::IMM_WIDTH){1'b0}},
                         instr[decode_pkg::IMM_WIDTH-1:0]};

    ////////////////////////////////////////
    // Opcode classes

    always_comb
    begin
        is_alu_rr = 1'b0;
        is_addi   = 1'b0;
        is_mul_op = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_known  = 1'b1;
        case (opcode)
            decode_pkg::OP_NOP:   is_known  = 1'b1;
            decode_pkg::OP_ADD,
            decode_pkg::OP_SUB,
            decode_pkg::OP_AND,
            decode_pkg::OP_OR:    is_alu_rr = 1'b1;
            decode_pkg::OP_ADDI:  is_addi   = 1'b1;
            decode_pkg::OP_MUL:   is_mul_op = 1'b1;
            decode_pkg::OP_LOAD:  is_load   = 1'b1;
            decode_pkg::OP_STORE: is_store  = 1'b1;
            default:              is_known  = 1'b0;
        endcase
    end

    assign dec.illegal = !is_known;
    assign dec.is_mul  = is_mul_op;

    // An illegal word sets no class and so neither reads nor writes registers
    assign dec.uses_src1 = is_alu_rr || is_addi || is_mul_op || is_load || is_store;
    assign dec.uses_src2 = is_alu_rr || is_mul_op || is_store;
    assign dec.writes_rd = is_alu_rr || is_addi || is_mul_op || is_load;

    // An illegal word must never reserve a destination in the scoreboard
    always_comb
    begin
        a_illegal_no_write: assert final (!(dec.illegal && dec.writes_rd))
            else $error("illegal instruction marked as writing rd");
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  logic                  clock,
    input  logic                  reset,
    decoded_if.rf_sink            dec,
    writeback_if.receiver         wb,
    output decode_pkg::reg_data_t ra_data,
    output decode_pkg::reg_data_t rb_data
);

    decode_pkg::reg_data_t regs [decode_pkg::NUM_REGS];
    logic                  bypass_a;
    logic                  bypass_b;

    ////////////////////////////////////////
    // Write port

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.wb_valid)
        begin
            regs[wb.wb_addr] <= wb.wb_data;
        end
    end

    ////////////////////////////////////////
    // Read ports with writeback bypass

    assign bypass_a = wb.wb_valid && (wb.wb_addr == dec.ra_addr);
    assign bypass_b = wb.wb_valid && (wb.wb_addr == dec.src2_addr);

    // Same-cycle write wins over the stored value
    assign ra_data = bypass_a ? wb.wb_data : regs[dec.ra_addr];
    assign rb_data = bypass_b ? wb.wb_data : regs[dec.src2_addr];

endmodule

`default_nettype wire

// ==== scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module scoreboard
(
    input  logic                clock,
    input  logic                reset,
    input  logic                flush,
    input  logic                accept,
    decoded_if.sb_sink          dec,
    writeback_if.receiver       wb,
    output decode_pkg::rob_id_t rob_id,
    output decode_pkg::rob_id_t ticket_src1,
    output decode_pkg::rob_id_t ticket_src2,
    output logic                blocked_src1,
    output logic                blocked_src2
);

    // One bit per register that waits for an older result
    logic [decode_pkg::NUM_REGS-1:0] blocked;
    // Ticket of the youngest writer of each register
    decode_pkg::rob_id_t             tickets [decode_pkg::NUM_REGS];
    decode_pkg::rob_id_t             tail;
    logic                            wb_retires;
    logic                            wb_frees_src1;
    logic                            wb_frees_src2;

    ////////////////////////////////////////
    // Lookup

    // Only the writer holding the current ticket releases a register
    assign wb_retires    = wb.wb_valid && (tickets[wb.wb_addr] == wb.wb_rob_id);
    assign wb_frees_src1 = wb_retires && (wb.wb_addr == dec.ra_addr);
    assign wb_frees_src2 = wb_retires && (wb.wb_addr == dec.src2_addr);

    assign ticket_src1 = tickets[dec.ra_addr];
    assign ticket_src2 = tickets[dec.src2_addr];

    assign blocked_src1 = dec.uses_src1 && blocked[dec.ra_addr] && !wb_frees_src1;
    assign blocked_src2 = dec.uses_src2 && blocked[dec.src2_addr] && !wb_frees_src2;

    assign rob_id = tail;

    ////////////////////////////////////////
    // Updates

    always_ff @(posedge clock)
    begin
        if (reset || flush)
        begin
            blocked <= '0;
            tail    <= '0;
        end
        else
        begin
            if (wb_retires)
            begin
                blocked[wb.wb_addr] <= 1'b0;
            end
            // New reservation overrides a release of the same register
            if (accept)
            begin
                tail <= tail + 1'b1;
                if (dec.writes_rd)
                begin
                    blocked[dec.rd_addr] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++)
            begin
                tickets[i] <= '0;
            end
        end
        else if (accept && dec.writes_rd)
        begin
            tickets[dec.rd_addr] <= tail;
        end
    end

    // Top level must mask accept with flush
    a_no_accept_on_flush: assert property (@(posedge clock) disable iff (reset)
        !(accept && flush))
        else $error("instruction accepted during flush");

endmodule

`default_nettype wire

// ==== dispatch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  accept,
    decoded_if.dispatch_sink      dec,
    input  decode_pkg::pc_t       pc,
    input  decode_pkg::reg_data_t ra_data,
    input  decode_pkg::reg_data_t rb_data,
    input  decode_pkg::rob_id_t   rob_id,
    input  decode_pkg::rob_id_t   ticket_src1,
    input  decode_pkg::rob_id_t   ticket_src2,
    input  logic                  blocked_src1,
    input  logic                  blocked_src2,

    output logic                  alu_valid,
    output logic                  mul_valid,

    output decode_pkg::opcode_t   issue_opcode,
    output decode_pkg::reg_addr_t issue_rd,
    output decode_pkg::reg_data_t issue_ra_data,
    output decode_pkg::reg_data_t issue_rb_data,
    output decode_pkg::offset_t   issue_offset,
    output decode_pkg::pc_t       issue_pc,
    output decode_pkg::rob_id_t   issue_rob_id,
    output decode_pkg::rob_id_t   issue_ticket_src1,
    output decode_pkg::rob_id_t   issue_ticket_src2,
    output logic                  issue_blocked_src1,
    output logic                  issue_blocked_src2,
    output logic                  issue_illegal
);

    ////////////////////////////////////////
    // Valid bits

    always_ff @(posedge clock)
    begin
        if (reset || flush)
        begin
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
        end
        else if (accept)
        begin
            // Illegal opcodes go to the ALU to raise the fault
            alu_valid <= !dec.is_mul;
            mul_valid <= dec.is_mul;
        end
        else if (!stall)
        begin
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Shared payload for both units

    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            issue_opcode       <= dec.opcode;
            issue_rd           <= dec.rd_addr;
            issue_ra_data      <= ra_data;
            issue_rb_data      <= rb_data;
            issue_offset       <= dec.offset;
            issue_pc           <= pc;
            issue_rob_id       <= rob_id;
            issue_ticket_src1  <= ticket_src1;
            issue_ticket_src2  <= ticket_src2;
            issue_blocked_src1 <= blocked_src1;
            issue_blocked_src2 <= blocked_src2;
            issue_illegal      <= dec.illegal;
        end
    end

    a_one_unit: assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mul_valid))
        else $error("ALU and multiplier issued in the same cycle");

endmodule

`default_nettype wire

// ==== decode_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_top
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,

    // Fetched instruction
    input  logic                  fetch_valid,
    input  decode_pkg::instr_t    fetch_instr,
    input  decode_pkg::pc_t       fetch_pc,

    // Register file write
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::reg_data_t wb_data,
    input  decode_pkg::rob_id_t   wb_rob_id,

    // Issue to ALU or multiplier
    output logic                  alu_valid,
    output logic                  mul_valid,
    output decode_pkg::opcode_t   issue_opcode,
    output decode_pkg::reg_addr_t issue_rd,
    output decode_pkg::reg_data_t issue_ra_data,
    output decode_pkg::reg_data_t issue_rb_data,
    output decode_pkg::offset_t   issue_offset,
    output decode_pkg::pc_t       issue_pc,
    output decode_pkg::rob_id_t   issue_rob_id,
    output decode_pkg::rob_id_t   issue_ticket_src1,
    output decode_pkg::rob_id_t   issue_ticket_src2,
    output logic                  issue_blocked_src1,
    output logic                  issue_blocked_src2,
    output logic                  issue_illegal
);

    decoded_if   dec_bus ();
    writeback_if wb_bus ();

    logic                  accept;
    decode_pkg::reg_data_t ra_data;
    decode_pkg::reg_data_t rb_data;
    decode_pkg::rob_id_t   rob_id;
    decode_pkg::rob_id_t   ticket_src1;
    decode_pkg::rob_id_t   ticket_src2;
    logic                  blocked_src1;
    logic                  blocked_src2;

    // Single acceptance condition for every stateful block
    assign accept = fetch_valid && !stall && !flush;

    assign wb_bus.wb_valid  = wb_valid;
    assign wb_bus.wb_addr   = wb_addr;
    assign wb_bus.wb_data   = wb_data;
    assign wb_bus.wb_rob_id = wb_rob_id;

    ////////////////////////////////////////
    // Blocks

    instr_decoder i_instr_decoder
    (
        .instr (fetch_instr),
        .dec   (dec_bus)
    );

    reg_file i_reg_file
    (
        .clock   (clock),
        .reset   (reset),
        .dec     (dec_bus),
        .wb      (wb_bus),
        .ra_data (ra_data),
        .rb_data (rb_data)
    );

    scoreboard i_scoreboard
    (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .accept       (accept),
        .dec          (dec_bus),
        .wb           (wb_bus),
        .rob_id       (rob_id),
        .ticket_src1  (ticket_src1),
        .ticket_src2  (ticket_src2),
        .blocked_src1 (blocked_src1),
        .blocked_src2 (blocked_src2)
    );

    dispatch_stage i_dispatch_stage
    (
        .clock              (clock),
        .reset              (reset),
        .stall              (stall),
        .flush              (flush),
        .accept             (accept),
        .dec                (dec_bus),
        .pc                 (fetch_pc),
        .ra_data            (ra_data),
        .rb_data            (rb_data),
        .rob_id             (rob_id),
        .ticket_src1        (ticket_src1),
        .ticket_src2        (ticket_src2),
        .blocked_src1       (blocked_src1),
        .blocked_src2       (blocked_src2),
        .alu_valid          (alu_valid),
        .mul_valid          (mul_valid),
        .issue_opcode       (issue_opcode),
        .issue_rd           (issue_rd),
        .issue_ra_data      (issue_ra_data),
        .issue_rb_data      (issue_rb_data),
        .issue_offset       (issue_offset),
        .issue_pc           (issue_pc),
        .issue_rob_id       (issue_rob_id),
        .issue_ticket_src1  (issue_ticket_src1),
        .issue_ticket_src2  (issue_ticket_src2),
        .issue_blocked_src1 (issue_blocked_src1),
        .issue_blocked_src2 (issue_blocked_src2),
        .issue_illegal      (issue_illegal)
    );

endmodule

`default_nettype wire

// ==== decode_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_tb;

    // Test sequence runs about 140 cycles including idle gaps
    localparam int TIMEOUT_CYCLES = 2000;

    logic                  clock;
    logic                  reset;
    logic                  stall;
    logic                  flush;
    logic                  fetch_valid;
    decode_pkg::instr_t    fetch_instr;
    decode_pkg::pc_t       fetch_pc;
    logic                  wb_valid;
    decode_pkg::reg_addr_t wb_addr;
    decode_pkg::reg_data_t wb_data;
    decode_pkg::rob_id_t   wb_rob_id;

    logic                  alu_valid;
    logic                  mul_valid;
    decode_pkg::opcode_t   issue_opcode;
    decode_pkg::reg_addr_t issue_rd;
    decode_pkg::reg_data_t issue_ra_data;
    decode_pkg::reg_data_t issue_rb_data;
    decode_pkg::offset_t   issue_offset;
    decode_pkg::pc_t       issue_pc;
    decode_pkg::rob_id_t   issue_rob_id;
    decode_pkg::rob_id_t   issue_ticket_src1;
    decode_pkg::rob_id_t   issue_ticket_src2;
    logic                  issue_blocked_src1;
    logic                  issue_blocked_src2;
    logic                  issue_illegal;

    // Reference model state
    decode_pkg::reg_data_t m_regs [decode_pkg::NUM_REGS];
    decode_pkg::rob_id_t   m_ticket [decode_pkg::NUM_REGS];
    logic [31:0]           m_blocked;
    decode_pkg::rob_id_t   m_tail;

    // Expected issue outputs
    logic                  exp_alu;
    logic                  exp_mul;
    logic [6:0]            exp_opcode;
    decode_pkg::reg_addr_t exp_rd;
    decode_pkg::reg_data_t exp_ra_data;
    decode_pkg::reg_data_t exp_rb_data;
    decode_pkg::offset_t   exp_offset;
    decode_pkg::pc_t       exp_pc;
    decode_pkg::rob_id_t   exp_rob_id;
    decode_pkg::rob_id_t   exp_ticket_src1;
    decode_pkg::rob_id_t   exp_ticket_src2;
    logic                  exp_blocked_src1;
    logic                  exp_blocked_src2;
    logic                  exp_illegal;

    integer                seed = 29810;
    logic [31:0]           rnd;
    int                    cycle_count = 0;
    int                    error_count = 0;
    int                    accepted_count = 0;
    int                    test_start_errors = 0;
    decode_pkg::rob_id_t   t5;
    logic [6:0]            test_ops [11] = '{7'd6, 7'd1, 7'd5, 7'd7, 7'd8, 7'd0,
                                             7'd2, 7'd3, 7'd4, 7'h7f, 7'h09};

    decode_top i_decode_top (.*);

    always #50 clock = ~clock;

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model

    always @(posedge clock)
    begin : reference_model
        int                    op;
        logic                  known;
        logic                  is_mul;
        logic                  uses1;
        logic                  uses2;
        logic                  writes;
        logic                  rel;
        logic                  accepted;
        decode_pkg::reg_addr_t rd;
        decode_pkg::reg_addr_t ra;
        decode_pkg::reg_addr_t src2;
        op       = fetch_instr[31:25];
        rd       = fetch_instr[24:20];
        ra       = fetch_instr[19:15];
        known    = (op <= 8);
        is_mul   = (op == 6);
        uses1    = known && (op != 0);
        uses2    = (op >= 1 && op <= 4) || (op == 6) || (op == 8);
        writes   = (op >= 1 && op <= 7);
        src2     = (op == 8) ? rd : fetch_instr[14:10];
        rel      = wb_valid && (m_ticket[wb_addr] == wb_rob_id);
        accepted = fetch_valid && !stall && !flush;
        if (reset)
        begin
            for (int i = 0; i < decode_pkg::NUM_REGS; i++)
            begin
                m_regs[i]   <= '0;
                m_ticket[i] <= '0;
            end
            m_blocked <= '0;
            m_tail    <= '0;
            exp_alu   <= 1'b0;
            exp_mul   <= 1'b0;
        end
        else
        begin
            if (flush)
            begin
                m_blocked <= '0;
                m_tail    <= '0;
                exp_alu   <= 1'b0;
                exp_mul   <= 1'b0;
            end
            else
            begin
                if (rel)
                    m_blocked[wb_addr] <= 1'b0;
                if (accepted)
                begin
                    accepted_count   = accepted_count + 1;
                    exp_alu          <= !is_mul;
                    exp_mul          <= is_mul;
                    exp_opcode       <= op[6:0];
                    exp_rd           <= rd;
                    exp_ra_data      <= (wb_valid && wb_addr == ra) ? wb_data : m_regs[ra];
                    exp_rb_data      <= (wb_valid && wb_addr == src2) ? wb_data : m_regs[src2];
                    exp_offset       <= {17'b0, fetch_instr[14:0]};
                    exp_pc           <= fetch_pc;
                    exp_rob_id       <= m_tail;
                    exp_ticket_src1  <= m_ticket[ra];
                    exp_ticket_src2  <= m_ticket[src2];
                    exp_blocked_src1 <= uses1 && m_blocked[ra] && !(rel && wb_addr == ra);
                    exp_blocked_src2 <= uses2 && m_blocked[src2] && !(rel && wb_addr == src2);
                    exp_illegal      <= !known;
                    m_tail           <= m_tail + 1'b1;
                    // Reservation wins over a same-cycle release
                    if (writes)
                    begin
                        m_blocked[rd] <= 1'b1;
                        m_ticket[rd]  <= m_tail;
                    end
                end
                else if (!stall)
                begin
                    exp_alu <= 1'b0;
                    exp_mul <= 1'b0;
                end
            end
            if (wb_valid)
                m_regs[wb_addr] <= wb_data;
        end
    end

    ////////////////////////////////////////
    // Checks

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        error_count++;
        $display("[FAIL] %s: got 0x%0h, expected 0x%0h (cycle %0d)",
                 name, got, expected, cycle_count);
    endtask

    property holds_when_issued(logic ok);
        @(posedge clock) disable iff (reset) (exp_alu || exp_mul) |-> ok;
    endproperty

    a_alu_valid: assert property (@(posedge clock) disable iff (reset) alu_valid == exp_alu)
        else report_value("alu_valid", $sampled(alu_valid), $sampled(exp_alu));
    a_mul_valid: assert property (@(posedge clock) disable iff (reset) mul_valid == exp_mul)
        else report_value("mul_valid", $sampled(mul_valid), $sampled(exp_mul));
    a_opcode: assert property (holds_when_issued(issue_opcode == exp_opcode))
        else report_value("issue_opcode", $sampled(issue_opcode), $sampled(exp_opcode));
    a_rd: assert property (holds_when_issued(issue_rd == exp_rd))
        else report_value("issue_rd", $sampled(issue_rd), $sampled(exp_rd));
    a_ra_data: assert property (holds_when_issued(issue_ra_data == exp_ra_data))
        else report_value("issue_ra_data", $sampled(issue_ra_data), $sampled(exp_ra_data));
    a_rb_data: assert property (holds_when_issued(issue_rb_data == exp_rb_data))
        else report_value("issue_rb_data", $sampled(issue_rb_data), $sampled(exp_rb_data));
    a_offset: assert property (holds_when_issued(issue_offset == exp_offset))
        else report_value("issue_offset", $sampled(issue_offset), $sampled(exp_offset));
    a_pc: assert property (holds_when_issued(issue_pc == exp_pc))
        else report_value("issue_pc", $sampled(issue_pc), $sampled(exp_pc));
    a_rob_id: assert property (holds_when_issued(issue_rob_id == exp_rob_id))
        else report_value("issue_rob_id", $sampled(issue_rob_id), $sampled(exp_rob_id));
    a_ticket1: assert property (holds_when_issued(issue_ticket_src1 == exp_ticket_src1))
        else report_value("issue_ticket_src1", $sampled(issue_ticket_src1),
                          $sampled(exp_ticket_src1));
    a_ticket2: assert property (holds_when_issued(issue_ticket_src2 == exp_ticket_src2))
        else report_value("issue_ticket_src2", $sampled(issue_ticket_src2),
                          $sampled(exp_ticket_src2));
    a_blocked1: assert property (holds_when_issued(issue_blocked_src1 == exp_blocked_src1))
        else report_value("issue_blocked_src1", $sampled(issue_blocked_src1),
                          $sampled(exp_blocked_src1));
    a_blocked2: assert property (holds_when_issued(issue_blocked_src2 == exp_blocked_src2))
        else report_value("issue_blocked_src2", $sampled(issue_blocked_src2),
                          $sampled(exp_blocked_src2));
    a_illegal: assert property (holds_when_issued(issue_illegal == exp_illegal))
        else report_value("issue_illegal", $sampled(issue_illegal), $sampled(exp_illegal));

    ////////////////////////////////////////
    // Stimulus helpers

    function automatic decode_pkg::instr_t encode(input logic [6:0] op,
                                                  input decode_pkg::reg_addr_t rd,
                                                  input decode_pkg::reg_addr_t ra,
                                                  input logic [14:0] low);
        return {op, rd, ra, low};
    endfunction

    task automatic drive_cycle(input logic valid, input decode_pkg::instr_t instr,
                               input logic wbv, input decode_pkg::reg_addr_t wa,
                               input decode_pkg::reg_data_t wd,
                               input decode_pkg::rob_id_t wid);
        @(posedge clock);
        stall       <= 1'b0;
        flush       <= 1'b0;
        fetch_valid <= valid;
        fetch_instr <= instr;
        fetch_pc    <= fetch_pc + 32'd4;
        wb_valid    <= wbv;
        wb_addr     <= wa;
        wb_data     <= wd;
        wb_rob_id   <= wid;
    endtask

    task automatic send(input decode_pkg::instr_t instr);
        drive_cycle(1'b1, instr, 1'b0, '0, '0, '0);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
            drive_cycle(1'b0, '0, 1'b0, '0, '0, '0);
    endtask

    // Fetch keeps offering an instruction that must not be taken
    task automatic hold_control(input logic do_stall, input logic do_flush);
        @(posedge clock);
        stall       <= do_stall;
        flush       <= do_flush;
        fetch_valid <= 1'b1;
        fetch_instr <= encode(7'd6, 5'd22, 5'd1, 15'h0400);
        wb_valid    <= 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        idle(3);
        $display("Test %0d %s: %0d errors", num, name, error_count - test_start_errors);
        test_start_errors = error_count;
    endtask

    ////////////////////////////////////////
    // Tests

    initial
    begin
        clock       = 1'b0;
        reset       = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_instr = '0;
        fetch_pc    = 32'h1000;
        wb_valid    = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        wb_rob_id   = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // Enough instructions to wrap the 64-entry ticket space
        idle(3);
        repeat (70)
        begin
            rnd = $random(seed);
            send(encode(7'd0, rnd[4:0], rnd[9:5], rnd[24:10]));
        end
        end_test(1, "reset and rob id wrap");

        for (int i = 0; i < 11; i++)
        begin
            rnd = $random(seed);
            send(encode(test_ops[i], rnd[4:0], rnd[9:5], rnd[24:10]));
            if (i % 2 == 1)
                idle(1);
        end
        end_test(2, "opcode classes");

        for (int r = 1; r <= 4; r++)
        begin
            rnd = $random(seed);
            drive_cycle(1'b0, '0, 1'b1, r[4:0], rnd, 6'd63);
        end
        send(encode(7'd1, 5'd6, 5'd1, {5'd2, 10'h011}));
        send(encode(7'd8, 5'd3, 5'd4, {5'd9, 10'h023}));
        rnd = $random(seed);
        drive_cycle(1'b1, encode(7'd1, 5'd7, 5'd8, {5'd9, 10'h0}), 1'b1, 5'd8, rnd, 6'd63);
        rnd = $random(seed);
        drive_cycle(1'b1, encode(7'd2, 5'd7, 5'd10, {5'd11, 10'h0}), 1'b1, 5'd11, rnd, 6'd63);
        end_test(3, "operand read and bypass");

        send(encode(7'd1, 5'd5, 5'd1, {5'd2, 10'h0}));
        send(encode(7'd1, 5'd10, 5'd5, {5'd5, 10'h0}));
        idle(1);
        t5 = m_ticket[5];
        drive_cycle(1'b0, '0, 1'b1, 5'd5, 32'h0bad_0005, t5 + 1'b1);
        send(encode(7'd1, 5'd11, 5'd5, {5'd1, 10'h0}));
        drive_cycle(1'b0, '0, 1'b1, 5'd5, 32'h0600_0005, t5);
        send(encode(7'd1, 5'd12, 5'd5, {5'd1, 10'h0}));
        send(encode(7'd1, 5'd5, 5'd2, {5'd3, 10'h0}));
        idle(2);
        t5 = m_ticket[5];
        drive_cycle(1'b1, encode(7'd1, 5'd13, 5'd5, {5'd2, 10'h0}), 1'b1, 5'd5,
                    32'h0700_0005, t5);
        end_test(4, "scoreboard blocking");

        send(encode(7'd1, 5'd14, 5'd1, {5'd2, 10'h0}));
        repeat (3)
            hold_control(1'b1, 1'b0);
        send(encode(7'd5, 5'd15, 5'd14, 15'h7abc));
        send(encode(7'd1, 5'd20, 5'd1, {5'd2, 10'h0}));
        hold_control(1'b0, 1'b1);
        send(encode(7'd1, 5'd21, 5'd20, {5'd20, 10'h0}));
        end_test(5, "stall and flush");

        $display("Accepted %0d instructions, %0d errors", accepted_count, error_count);
        if (error_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
decode_pkg.sv
decoded_if.sv
writeback_if.sv
instr_decoder.sv
reg_file.sv
scoreboard.sv
dispatch_stage.sv
decode_top.sv
decode_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - decode_pkg.sv
  - decoded_if.sv
  - writeback_if.sv
  - instr_decoder.sv
  - reg_file.sv
  - scoreboard.sv
  - dispatch_stage.sv
  - decode_top.sv
  - target: test
    files:
      - decode_tb.sv
